// ==== isaPkg.sv ====
package isaPkg;

	// ==================================================
	// datapath widths.
	// ==================================================
	localparam int wordBits = 32;
	localparam int regIdxBits = 4;
	localparam int opBits = 5;
	localparam int immBits = 19;

	// ==================================================
	// opcodes.
	// ==================================================
	// add is zero so an idle control word selects add.
	typedef enum logic [opBits-1:0] {
		opAdd = 5'd0,
		opSub = 5'd1,
		opAnd = 5'd2,
		opOr = 5'd3,
		opShl = 5'd4,
		opShr = 5'd5,
		opAddi = 5'd6,
		opLd = 5'd7,
		opSt = 5'd8,
		opBrzr = 5'd9,
		opOut = 5'd10,
		opHalt = 5'd11
	} opcodeT;

	// instruction word with the msb first.
	// rc occupies the top four bits of imm (bits 18 to 15).
	typedef struct packed {
		opcodeT op;
		logic [regIdxBits-1:0] ra;
		logic [regIdxBits-1:0] rb;
		logic [immBits-1:0] imm;
	} instrT;

endpackage

// ==== ctrlPkg.sv ====
package ctrlPkg;

	// ==================================================
	// bus drivers.
	// ==================================================
	typedef enum logic [2:0] {
		srcNone = 3'd0,
		srcReg = 3'd1,
		srcPc = 3'd2,
		srcMdr = 3'd3,
		srcZlow = 3'd4,
		srcConst = 3'd5
	} busSrcT;

	// ==================================================
	// sequencer states.
	// ==================================================
	typedef enum logic [3:0] {
		stIdle = 4'd0,
		stT0 = 4'd1,
		stT1 = 4'd2,
		stT2 = 4'd3,
		stT3 = 4'd4,
		stT4 = 4'd5,
		stT5 = 4'd6,
		stT6 = 4'd7,
		stT7 = 4'd8,
		stHalt = 4'd9
	} stateT;

	// one control word per phase.
	typedef struct packed {
		logic gra;
		logic grb;
		logic grc;
		logic rin;
		logic baout;
		busSrcT busSrc;
		logic yin;
		logic zin;
		logic pcin;
		logic irin;
		logic marin;
		logic mdrin;
		logic outin;
		logic conin;
		logic read;
		logic write;
		logic incPc;
		isaPkg::opcodeT aluOp;
	} ctrlWordT;

endpackage

// ==== instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode (
	input logic Clock,
	input logic arstN,
	input isaPkg::instrT ir,
	input ctrlPkg::ctrlWordT ctrl,
	input logic [isaPkg::wordBits-1:0] bus,
	output logic [isaPkg::regIdxBits-1:0] regSel,
	output logic [isaPkg::wordBits-1:0] constVal,
	output logic conFlag
);

	localparam int extBits = isaPkg::wordBits - isaPkg::immBits;

	logic [isaPkg::regIdxBits-1:0] rc;

	// rc shares bits with the constant.
	assign rc = ir.imm[isaPkg::immBits-1 -: isaPkg::regIdxBits];

	// register number from gra/grb/grc.
	always_comb begin
		if (ctrl.gra) begin
			regSel = ir.ra;
		end else if (ctrl.grb) begin
			regSel = ir.rb;
		end else if (ctrl.grc) begin
			regSel = rc;
		end else begin
			regSel = '0;
		end
	end

	assign constVal = {{extBits{ir.imm[isaPkg::immBits-1]}}, ir.imm};

	// CON flip-flop for branch if zero.
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			conFlag <= 1'b0;
		end else if (ctrl.conin) begin
			conFlag <= (bus == '0);
		end
	end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input logic Clock,
	input logic arstN,
	input logic run,
	input isaPkg::opcodeT opcode,
	input logic conFlag,
	output ctrlPkg::ctrlWordT ctrl,
	output logic halted,
	output logic idle
);

	ctrlPkg::stateT state;
	ctrlPkg::stateT nextState;
	logic regOp;
	logic memOp;

	// three-register ALU instructions.
	assign regOp = opcode inside {isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd,
		isaPkg::opOr, isaPkg::opShl, isaPkg::opShr};
	assign memOp = opcode inside {isaPkg::opLd, isaPkg::opSt};

	// ==================================================
	// phase sequencing.
	// ==================================================
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= ctrlPkg::stIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			ctrlPkg::stIdle: if (run) nextState = ctrlPkg::stT0;
			ctrlPkg::stT0: nextState = ctrlPkg::stT1;
			ctrlPkg::stT1: nextState = ctrlPkg::stT2;
			ctrlPkg::stT2: nextState = ctrlPkg::stT3;
			ctrlPkg::stT3: begin
				if (opcode == isaPkg::opHalt) begin
					nextState = ctrlPkg::stHalt;
				end else if (regOp || memOp || opcode == isaPkg::opAddi
						|| opcode == isaPkg::opBrzr) begin
					nextState = ctrlPkg::stT4;
				end else begin
					nextState = ctrlPkg::stT0;
				end
			end
			ctrlPkg::stT4: begin
				if (opcode == isaPkg::opBrzr && !conFlag) begin
					nextState = ctrlPkg::stT0;
				end else begin
					nextState = ctrlPkg::stT5;
				end
			end
			ctrlPkg::stT5: nextState = memOp || opcode == isaPkg::opBrzr ?
				ctrlPkg::stT6 : ctrlPkg::stT0;
			ctrlPkg::stT6: nextState = memOp ? ctrlPkg::stT7 : ctrlPkg::stT0;
			ctrlPkg::stT7: nextState = ctrlPkg::stT0;
			ctrlPkg::stHalt: nextState = ctrlPkg::stHalt;
			default: nextState = ctrlPkg::stIdle;
		endcase
	end

	// ==================================================
	// control word decoded from the state register.
	// ==================================================
	always_comb begin
		ctrl = '0;
		case (state)
			ctrlPkg::stT0: begin
				ctrl.busSrc = ctrlPkg::srcPc;
				ctrl.marin = 1'b1;
				ctrl.incPc = 1'b1;
			end
			ctrlPkg::stT1: begin
				ctrl.read = 1'b1;
				ctrl.mdrin = 1'b1;
			end
			ctrlPkg::stT2: begin
				ctrl.busSrc = ctrlPkg::srcMdr;
				ctrl.irin = 1'b1;
			end
			ctrlPkg::stT3: begin
				if (regOp || memOp || opcode == isaPkg::opAddi) begin
					ctrl.grb = 1'b1;
					ctrl.baout = memOp;
					ctrl.busSrc = ctrlPkg::srcReg;
					ctrl.yin = 1'b1;
				end else if (opcode == isaPkg::opBrzr || opcode == isaPkg::opOut) begin
					ctrl.gra = 1'b1;
					ctrl.busSrc = ctrlPkg::srcReg;
					ctrl.conin = (opcode == isaPkg::opBrzr);
					ctrl.outin = (opcode == isaPkg::opOut);
				end
			end
			ctrlPkg::stT4: begin
				if (regOp) begin
					ctrl.grc = 1'b1;
					ctrl.busSrc = ctrlPkg::srcReg;
					ctrl.zin = 1'b1;
					ctrl.aluOp = opcode;
				end else if (opcode == isaPkg::opBrzr) begin
					ctrl.busSrc = ctrlPkg::srcPc;
					ctrl.yin = conFlag;
				end else begin
					ctrl.busSrc = ctrlPkg::srcConst;
					ctrl.zin = 1'b1;
					ctrl.aluOp = isaPkg::opAdd;
				end
			end
			ctrlPkg::stT5: begin
				if (opcode == isaPkg::opBrzr) begin
					ctrl.busSrc = ctrlPkg::srcConst;
					ctrl.zin = 1'b1;
					ctrl.aluOp = isaPkg::opAdd;
				end else begin
					ctrl.busSrc = ctrlPkg::srcZlow;
					ctrl.marin = memOp;
					ctrl.gra = !memOp;
					ctrl.rin = !memOp;
				end
			end
			ctrlPkg::stT6: begin
				if (opcode == isaPkg::opBrzr) begin
					ctrl.busSrc = ctrlPkg::srcZlow;
					ctrl.pcin = 1'b1;
				end else if (opcode == isaPkg::opSt) begin
					ctrl.gra = 1'b1;
					ctrl.busSrc = ctrlPkg::srcReg;
					ctrl.mdrin = 1'b1;
				end else begin
					ctrl.read = 1'b1;
					ctrl.mdrin = 1'b1;
				end
			end
			ctrlPkg::stT7: begin
				if (opcode == isaPkg::opSt) begin
					ctrl.write = 1'b1;
				end else begin
					ctrl.busSrc = ctrlPkg::srcMdr;
					ctrl.gra = 1'b1;
					ctrl.rin = 1'b1;
				end
			end
			default: ctrl = '0;
		endcase
	end

	assign halted = (state == ctrlPkg::stHalt);
	assign idle = (state == ctrlPkg::stIdle);

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic Clock,
	input logic arstN,
	input logic [isaPkg::regIdxBits-1:0] regSel,
	input logic rin,
	input logic baout,
	input logic [isaPkg::wordBits-1:0] bus,
	output logic [isaPkg::wordBits-1:0] regOut
);

	localparam int numRegs = 1 << isaPkg::regIdxBits;

	logic [isaPkg::wordBits-1:0] regs [numRegs];

	// R0 is a real register; only BAout hides it.
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (rin) begin
			regs[regSel] <= bus;
		end
	end

	// base address reads of R0 give zero.
	always_comb begin
		if (baout && regSel == '0) begin
			regOut = '0;
		end else begin
			regOut = regs[regSel];
		end
	end

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute (
	input logic Clock,
	input logic arstN,
	input logic [isaPkg::wordBits-1:0] bus,
	input logic yin,
	input logic zin,
	input isaPkg::opcodeT aluOp,
	output logic [isaPkg::wordBits-1:0] zLow
);

	localparam int w = isaPkg::wordBits;
	localparam int shiftBits = $clog2(isaPkg::wordBits);

	logic [w-1:0] y;
	logic [2*w-1:0] z;
	logic [2*w-1:0] result;
	logic [w:0] sum;
	logic [w:0] diff;
	logic [shiftBits-1:0] shamt;

	always_ff @(posedge Clock) begin
		if (yin) begin
			y <= bus;
		end
	end

	assign sum = {1'b0, y} + {1'b0, bus};
	assign diff = {1'b0, y} - {1'b0, bus};
	assign shamt = bus[shiftBits-1:0];

	// ==================================================
	// Y op bus.
	// ==================================================
	// high half holds sign copies above the carry or borrow bit.
	always_comb begin
		result = {{(w-1){sum[w-1]}}, sum[w], sum[w-1:0]};
		case (aluOp)
			isaPkg::opSub: result = {{(w-1){diff[w-1]}}, diff[w], diff[w-1:0]};
			isaPkg::opAnd: result = {{w{1'b0}}, y & bus};
			isaPkg::opOr: result = {{w{1'b0}}, y | bus};
			// bits shifted out land in the high half.
			isaPkg::opShl: result = {{w{1'b0}}, y} << shamt;
			isaPkg::opShr: result = {{w{1'b0}}, y >> shamt};
			default: ;
		endcase
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			z <= '0;
		end else if (zin) begin
			z <= result;
		end
	end

	assign zLow = z[w-1:0];

endmodule

// ==== memResult.sv ====
`timescale 1ns/1ps

module memResult #(
	parameter int memAddrBits = 8
) (
	input logic Clock,
	input logic arstN,
	input logic [isaPkg::wordBits-1:0] bus,
	input logic marin,
	input logic mdrin,
	input logic read,
	input logic write,
	input logic outin,
	input logic idle,
	input logic progWe,
	input logic [memAddrBits-1:0] progAddr,
	input logic [isaPkg::wordBits-1:0] progData,
	output logic [isaPkg::wordBits-1:0] mdrOut,
	output logic [isaPkg::wordBits-1:0] outPort,
	output logic outValid
);

	localparam int memWords = 1 << memAddrBits;

	logic [memAddrBits-1:0] mar;
	logic [isaPkg::wordBits-1:0] mdr;
	logic [isaPkg::wordBits-1:0] mem [memWords];

	always_ff @(posedge Clock) begin
		if (marin) begin
			mar <= bus[memAddrBits-1:0];
		end
		if (mdrin) begin
			mdr <= read ? mem[mar] : bus;
		end
	end

	// program load only while the sequencer is idle.
	always_ff @(posedge Clock) begin
		if (idle && progWe) begin
			mem[progAddr] <= progData;
		end else if (write) begin
			mem[mar] <= mdr;
		end
	end

	// output port and its valid pulse.
	always_ff @(posedge Clock) begin
		if (outin) begin
			outPort <= bus;
		end
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= outin;
		end
	end

	assign mdrOut = mdr;

endmodule

// ==== busDatapath.sv ====
`timescale 1ns/1ps

module busDatapath #(
	parameter int memAddrBits = 8
) (
	input logic Clock,
	input logic arstN,
	input ctrlPkg::ctrlWordT ctrl,
	input logic idle,
	input logic progWe,
	input logic [memAddrBits-1:0] progAddr,
	input logic [isaPkg::wordBits-1:0] progData,
	output isaPkg::opcodeT opcode,
	output logic conFlag,
	output logic [isaPkg::wordBits-1:0] outPort,
	output logic outValid
);

	localparam logic [isaPkg::wordBits-1:0] pcStep = 1;

	logic [isaPkg::wordBits-1:0] bus;
	logic [isaPkg::wordBits-1:0] pc;
	logic [isaPkg::wordBits-1:0] regOut;
	logic [isaPkg::wordBits-1:0] zLow;
	logic [isaPkg::wordBits-1:0] mdrOut;
	logic [isaPkg::wordBits-1:0] constVal;
	logic [isaPkg::regIdxBits-1:0] regSel;
	isaPkg::instrT ir;

	// ==================================================
	// PC and IR.
	// ==================================================
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (ctrl.pcin) begin
			pc <= bus;
		end else if (ctrl.incPc) begin
			pc <= pc + pcStep;
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.irin) begin
			ir <= isaPkg::instrT'(bus);
		end
	end

	assign opcode = ir.op;

	// single bus with one driver per cycle.
	always_comb begin
		case (ctrl.busSrc)
			ctrlPkg::srcNone: bus = '0;
			ctrlPkg::srcReg: bus = regOut;
			ctrlPkg::srcPc: bus = pc;
			ctrlPkg::srcMdr: bus = mdrOut;
			ctrlPkg::srcZlow: bus = zLow;
			ctrlPkg::srcConst: bus = constVal;
			default: bus = '0;
		endcase
	end

	instrDecode instrDecode_inst (
		.Clock(Clock),
		.arstN(arstN),
		.ir(ir),
		.ctrl(ctrl),
		.bus(bus),
		.regSel(regSel),
		.constVal(constVal),
		.conFlag(conFlag)
	);

	regFile regFile_inst (
		.Clock(Clock),
		.arstN(arstN),
		.regSel(regSel),
		.rin(ctrl.rin),
		.baout(ctrl.baout),
		.bus(bus),
		.regOut(regOut)
	);

	aluExecute aluExecute_inst (
		.Clock(Clock),
		.arstN(arstN),
		.bus(bus),
		.yin(ctrl.yin),
		.zin(ctrl.zin),
		.aluOp(ctrl.aluOp),
		.zLow(zLow)
	);

	memResult #(
		.memAddrBits(memAddrBits)
	) memResult_inst (
		.Clock(Clock),
		.arstN(arstN),
		.bus(bus),
		.marin(ctrl.marin),
		.mdrin(ctrl.mdrin),
		.read(ctrl.read),
		.write(ctrl.write),
		.outin(ctrl.outin),
		.idle(idle),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.mdrOut(mdrOut),
		.outPort(outPort),
		.outValid(outValid)
	);

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
	parameter int memAddrBits = 8
) (
	input logic Clock,
	input logic arstN,
	input logic run,
	input logic progWe,
	input logic [memAddrBits-1:0] progAddr,
	input logic [isaPkg::wordBits-1:0] progData,
	output logic [isaPkg::wordBits-1:0] outPort,
	output logic outValid,
	output logic halted
);

	ctrlPkg::ctrlWordT ctrl;
	isaPkg::opcodeT opcode;
	logic conFlag;
	logic idle;

	controlUnit controlUnit_inst (
		.Clock(Clock),
		.arstN(arstN),
		.run(run),
		.opcode(opcode),
		.conFlag(conFlag),
		.ctrl(ctrl),
		.halted(halted),
		.idle(idle)
	);

	busDatapath #(
		.memAddrBits(memAddrBits)
	) busDatapath_inst (
		.Clock(Clock),
		.arstN(arstN),
		.ctrl(ctrl),
		.idle(idle),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.opcode(opcode),
		.conFlag(conFlag),
		.outPort(outPort),
		.outValid(outValid)
	);

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
	input logic resetReq,
	output logic Clock,
	output logic arstN
);

	logic [1:0] rstCount = 2'd0;

	// 20 ns period.
	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	// reset held while requested and three cycles after.
	always @(posedge Clock or posedge resetReq) begin
		if (resetReq) begin
			rstCount <= 2'd3;
		end else if (rstCount != 2'd0) begin
			rstCount <= rstCount - 2'd1;
		end
	end

	assign arstN = (rstCount == 2'd0);

endmodule

// ==== cpuTop_checker.sv ====
`timescale 1ns/1ps

module cpuTop_checker (
	input logic Clock,
	input logic arstN,
	input logic outValid,
	input logic halted
);

	// valid is a single-cycle pulse.
	property validPulse;
		@(posedge Clock) disable iff (!arstN) outValid |=> !outValid;
	endproperty

	// only a reset leaves halt.
	property haltSticky;
		@(posedge Clock) disable iff (!arstN) halted |=> halted;
	endproperty

	property quietInReset;
		@(posedge Clock) !arstN |-> (!outValid && !halted);
	endproperty

	validPulseA: assert property (validPulse) else $error("outValid high for two cycles");
	haltStickyA: assert property (haltSticky) else $error("halted fell without reset");
	quietInResetA: assert property (quietInReset) else $error("outputs active in reset");

endmodule

bind cpuTop cpuTop_checker cpuTop_checker_inst (
	.Clock(Clock),
	.arstN(arstN),
	.outValid(outValid),
	.halted(halted)
);

// ==== cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

	localparam int memBits = 8;
	localparam int maxCycles = 3000;

	logic Clock;
	logic arstN;
	logic resetReq;
	logic run;
	logic progWe;
	logic [memBits-1:0] progAddr;
	logic [31:0] progData;
	logic [31:0] outPort;
	logic outValid;
	logic halted;

	logic [15:0] lfsr;
	logic [31:0] prog [$];
	logic [31:0] outs [$];
	logic [31:0] expOut [$];

	tbClock tbClock_inst (
		.resetReq(resetReq),
		.Clock(Clock),
		.arstN(arstN)
	);

	cpuTop #(
		.memAddrBits(memBits)
	) cpuTop_inst (
		.Clock(Clock),
		.arstN(arstN),
		.run(run),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.outPort(outPort),
		.outValid(outValid),
		.halted(halted)
	);

	// ==================================================
	// helpers.
	// ==================================================
	// fibonacci lfsr with taps 16 14 13 11.
	function automatic logic [31:0] randBits(int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] regInstr(isaPkg::opcodeT op, int ra, int rb, int rc);
		return {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
	endfunction

	function automatic logic [31:0] immInstr(isaPkg::opcodeT op, int ra, int rb,
			logic [18:0] imm);
		return {op, 4'(ra), 4'(rb), imm};
	endfunction

	function automatic logic [31:0] sext19(logic [18:0] x);
		return {{13{x[18]}}, x};
	endfunction

	task automatic failRun();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic checkWord(logic [31:0] got, logic [31:0] exp, string what);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			failRun();
		end
	endtask

	task automatic nextDrive();
		@(posedge Clock);
		#2;
	endtask

	task automatic applyReset();
		int n;
		run = 1'b0;
		progWe = 1'b0;
		nextDrive();
		resetReq = 1'b1;
		nextDrive();
		resetReq = 1'b0;
		n = 0;
		while (arstN !== 1'b1) begin
			nextDrive();
			n++;
			if (n > 10) begin
				$display("reset was never released");
				failRun();
			end
		end
	endtask

	task automatic loadWord(int addr, logic [31:0] data);
		progWe = 1'b1;
		progAddr = memBits'(addr);
		progData = data;
		nextDrive();
		progWe = 1'b0;
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			loadWord(i, prog[i]);
		end
	endtask

	// collects every output until halted.
	task automatic runProgram();
		int n;
		outs.delete();
		run = 1'b1;
		n = 0;
		while (halted !== 1'b1) begin
			nextDrive();
			if (outValid === 1'b1) begin
				outs.push_back(outPort);
			end
			n++;
			if (n > maxCycles) begin
				$display("timed out waiting for the program to halt");
				failRun();
			end
		end
		run = 1'b0;
	endtask

	task automatic checkOutputs(string name);
		assert (outs.size() == expOut.size()) else begin
			$display("CHECK FAILED at %0t: %s gave %0d outputs, expected %0d",
				$time, name, outs.size(), expOut.size());
			failRun();
		end
		foreach (expOut[i]) begin
			checkWord(outs[i], expOut[i], name);
		end
	endtask

	task automatic clearProg();
		prog.delete();
		expOut.delete();
	endtask

	// ==================================================
	// directed tests.
	// ==================================================
	task automatic testAluOps();
		logic [18:0] a;
		logic [18:0] b;
		logic [31:0] x;
		logic [31:0] y;
		clearProg();
		for (int k = 0; k < 3; k++) begin
			a = 19'(randBits(19));
			b = 19'(randBits(19));
			x = sext19(a);
			y = sext19(b);
			prog.push_back(immInstr(isaPkg::opAddi, 1, 0, a));
			prog.push_back(immInstr(isaPkg::opAddi, 2, 0, b));
			prog.push_back(regInstr(isaPkg::opAdd, 3, 1, 2));
			prog.push_back(regInstr(isaPkg::opOut, 3, 0, 0));
			prog.push_back(regInstr(isaPkg::opSub, 4, 1, 2));
			prog.push_back(regInstr(isaPkg::opOut, 4, 0, 0));
			prog.push_back(regInstr(isaPkg::opAnd, 5, 1, 2));
			prog.push_back(regInstr(isaPkg::opOut, 5, 0, 0));
			prog.push_back(regInstr(isaPkg::opOr, 6, 1, 2));
			prog.push_back(regInstr(isaPkg::opOut, 6, 0, 0));
			expOut.push_back(x + y);
			expOut.push_back(x - y);
			expOut.push_back(x & y);
			expOut.push_back(x | y);
		end
		prog.push_back(regInstr(isaPkg::opHalt, 0, 0, 0));
		applyReset();
		loadProgram();
		runProgram();
		checkOutputs("alu ops");
	endtask

	task automatic testShifts();
		logic [18:0] a;
		logic [4:0] sh;
		logic [31:0] x;
		clearProg();
		for (int k = 0; k < 4; k++) begin
			a = 19'(randBits(19));
			sh = 5'(randBits(5));
			x = sext19(a);
			prog.push_back(immInstr(isaPkg::opAddi, 1, 0, a));
			prog.push_back(immInstr(isaPkg::opAddi, 2, 0, {14'd0, sh}));
			prog.push_back(regInstr(isaPkg::opShl, 3, 1, 2));
			prog.push_back(regInstr(isaPkg::opOut, 3, 0, 0));
			prog.push_back(regInstr(isaPkg::opShr, 4, 1, 2));
			prog.push_back(regInstr(isaPkg::opOut, 4, 0, 0));
			expOut.push_back(x << sh);
			expOut.push_back(x >> sh);
		end
		prog.push_back(regInstr(isaPkg::opHalt, 0, 0, 0));
		applyReset();
		loadProgram();
		runProgram();
		checkOutputs("shifts");
	endtask

	// R0 holds 7, but a base address of R0 still reads zero.
	task automatic testAddiBaout();
		logic [31:0] d;
		clearProg();
		d = randBits(32);
		prog.push_back(immInstr(isaPkg::opAddi, 1, 0, 19'(-5)));
		prog.push_back(regInstr(isaPkg::opOut, 1, 0, 0));
		prog.push_back(immInstr(isaPkg::opAddi, 0, 0, 19'd7));
		prog.push_back(immInstr(isaPkg::opLd, 2, 0, 19'd200));
		prog.push_back(regInstr(isaPkg::opOut, 2, 0, 0));
		prog.push_back(immInstr(isaPkg::opAddi, 3, 0, 19'd1));
		prog.push_back(regInstr(isaPkg::opOut, 3, 0, 0));
		prog.push_back(regInstr(isaPkg::opHalt, 0, 0, 0));
		expOut.push_back(32'hFFFF_FFFB);
		expOut.push_back(d);
		expOut.push_back(32'd8);
		applyReset();
		loadProgram();
		loadWord(200, d);
		loadWord(207, ~d);
		runProgram();
		checkOutputs("addi and baout");
	endtask

	task automatic testStoreLoad();
		int addr;
		logic [18:0] v;
		logic [31:0] below;
		logic [31:0] above;
		clearProg();
		addr = 64 + int'(randBits(6));
		v = 19'(randBits(19));
		below = randBits(32);
		above = randBits(32);
		prog.push_back(immInstr(isaPkg::opAddi, 1, 0, v));
		prog.push_back(immInstr(isaPkg::opSt, 1, 0, 19'(addr)));
		prog.push_back(immInstr(isaPkg::opLd, 2, 0, 19'(addr)));
		prog.push_back(regInstr(isaPkg::opOut, 2, 0, 0));
		prog.push_back(immInstr(isaPkg::opLd, 3, 0, 19'(addr + 1)));
		prog.push_back(regInstr(isaPkg::opOut, 3, 0, 0));
		prog.push_back(immInstr(isaPkg::opLd, 4, 0, 19'(addr - 1)));
		prog.push_back(regInstr(isaPkg::opOut, 4, 0, 0));
		prog.push_back(regInstr(isaPkg::opHalt, 0, 0, 0));
		expOut.push_back(sext19(v));
		expOut.push_back(above);
		expOut.push_back(below);
		applyReset();
		loadProgram();
		loadWord(addr - 1, below);
		loadWord(addr, ~sext19(v));
		loadWord(addr + 1, above);
		runProgram();
		checkOutputs("store and load");
	endtask

	// offset 1 skips the next instruction.
	task automatic testBranch();
		clearProg();
		prog.push_back(immInstr(isaPkg::opAddi, 2, 0, 19'd5));
		prog.push_back(immInstr(isaPkg::opAddi, 3, 0, 19'd9));
		prog.push_back(immInstr(isaPkg::opBrzr, 1, 0, 19'd1));
		prog.push_back(regInstr(isaPkg::opOut, 3, 0, 0));
		prog.push_back(regInstr(isaPkg::opOut, 2, 0, 0));
		prog.push_back(immInstr(isaPkg::opBrzr, 2, 0, 19'd1));
		prog.push_back(regInstr(isaPkg::opOut, 3, 0, 0));
		prog.push_back(regInstr(isaPkg::opOut, 2, 0, 0));
		prog.push_back(regInstr(isaPkg::opHalt, 0, 0, 0));
		expOut.push_back(32'd5);
		expOut.push_back(32'd9);
		expOut.push_back(32'd5);
		applyReset();
		loadProgram();
		runProgram();
		checkOutputs("branch");
	endtask

	task automatic testHalt();
		logic [18:0] k;
		clearProg();
		k = 19'(randBits(19));
		prog.push_back(immInstr(isaPkg::opAddi, 1, 0, k));
		prog.push_back(regInstr(isaPkg::opOut, 1, 0, 0));
		prog.push_back(regInstr(isaPkg::opHalt, 0, 0, 0));
		expOut.push_back(sext19(k));
		applyReset();
		loadProgram();
		runProgram();
		checkOutputs("halt first run");
		for (int i = 0; i < 12; i++) begin
			// a program write while halted.
			progWe = (i == 3);
			progAddr = '0;
			progData = immInstr(isaPkg::opAddi, 1, 0, k + 19'd1);
			nextDrive();
			checkWord({31'd0, outValid}, 32'd0, "outValid after halt");
			checkWord({31'd0, halted}, 32'd1, "halted after halt");
		end
		progWe = 1'b0;
		applyReset();
		runProgram();
		checkOutputs("halt rerun");
	endtask

	initial begin
		lfsr = 16'd41469;
		resetReq = 1'b0;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		testAluOps();
		testShifts();
		testAddiBaout();
		testStoreLoad();
		testBranch();
		testHalt();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== list.f ====
isaPkg.sv
ctrlPkg.sv
instrDecode.sv
controlUnit.sv
regFile.sv
aluExecute.sv
memResult.sv
busDatapath.sv
cpuTop.sv
tbClock.sv
cpuTop_checker.sv
cpuTb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' list.f)

.PHONY: all run clean

all: run

obj_dir/VcpuTb: list.f $(SRCS)
	verilator --binary --timing --assert --top-module cpuTb -f list.f -o VcpuTb

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
